//--- logic/dram_pkg.sv
// Address widths, DRAM command and row-status encodings and refresh timing, imported by every block
package dram_pkg;

    // Address fields from high bits to low: row, bank group, bank, column
    localparam int COL_BITS  = 4;
    localparam int ROW_BITS  = 8;
    localparam int BANK_BITS = 2;
    localparam int BG_BITS   = 2;
    localparam int ADDR_BITS = ROW_BITS + BG_BITS + BANK_BITS + COL_BITS;

    localparam int DATA_BITS = 32;

    // One table entry per bank group and bank pair
    localparam int NUM_BANKS = 16;

    localparam int REFRESH_INTERVAL = 200;
    localparam int REF_CNT_BITS     = $clog2(REFRESH_INTERVAL);

    typedef enum logic [2:0] {
        NOP,
        ACT,
        RD,
        WR,
        PRE,
        PREA,
        REF
    } dram_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        HIT,
        MISS,
        CONFLICT
    } row_stat_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOOKUP,
        S_DECIDE,
        S_PRE,
        S_ACT,
        S_ACCESS,
        S_DONE,
        S_PREA,
        S_REF
    } sched_state_t;

endpackage

//--- logic/row_open_if.sv
// Lookup path from the command scheduler to the open-row table; ctrl side asks, dut side answers
`timescale 1ns/1ps

interface row_open_if;
    import dram_pkg::*;

    // Lookup request
    logic                 req_en;
    logic                 row_resolve;
    logic                 refresh;
    logic [BG_BITS-1:0]   bank_group;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;

    // Registered answer, one cycle after req_en
    row_stat_t            row_stat;
    logic [ROW_BITS-1:0]  row_conflict;

    modport dut (
        input  req_en, row_resolve, refresh, bank_group, bank, row,
        output row_stat, row_conflict
    );

    modport ctrl (
        output req_en, row_resolve, refresh, bank_group, bank, row,
        input  row_stat, row_conflict
    );

endinterface

//--- logic/bus_req_if.sv
// Granted host request from the port arbiter to the command scheduler, with its completion
`timescale 1ns/1ps

interface bus_req_if;
    import dram_pkg::*;

    // Held stable while valid, until done
    logic                 valid;
    logic                 we;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
    logic                 port;

    // Completion, high for one cycle
    logic                 done;
    logic [DATA_BITS-1:0] rdata;

    modport master (
        output valid, we, addr, wdata, port,
        input  done, rdata
    );

    modport slave (
        input  valid, we, addr, wdata, port,
        output done, rdata
    );

endinterface

//--- logic/row_open.sv
// Open-row table, one entry per bank; classifies scheduler lookups as hit, miss or conflict
`timescale 1ns/1ps

module row_open (
    input logic      CLK,
    input logic      nRST,
    row_open_if.dut  pol_if
);
    import dram_pkg::*;

    logic [$clog2(NUM_BANKS)-1:0] idx;
    logic [NUM_BANKS-1:0]         valid_q;
    logic [ROW_BITS-1:0]          row_q [NUM_BANKS];
    logic                         entry_valid;
    logic                         row_match;
    logic                         lookup;
    row_stat_t                    stat_n;

    assign idx         = {pol_if.bank_group, pol_if.bank};
    assign entry_valid = valid_q[idx];
    assign row_match   = row_q[idx] == pol_if.row;
    // Refresh wins over any lookup in the same cycle
    assign lookup      = pol_if.req_en && !pol_if.refresh;

    always_comb begin
        stat_n = IDLE;
        if (lookup) begin
            if (!entry_valid) begin
                stat_n = MISS;
            end else if (row_match) begin
                stat_n = HIT;
            end else if (!pol_if.row_resolve) begin
                stat_n = CONFLICT;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q         <= '0;
            pol_if.row_stat <= IDLE;
        end else begin
            pol_if.row_stat <= stat_n;
            if (pol_if.refresh) begin
                valid_q <= '0;
            end else if (lookup) begin
                if (!entry_valid) begin
                    valid_q[idx] <= 1'b1;
                end else if (pol_if.row_resolve) begin
                    // Bank is being precharged
                    valid_q[idx] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (lookup && !entry_valid) begin
            row_q[idx] <= pol_if.row;
        end
        // Row that has to be closed, held until the next conflict
        if (stat_n == CONFLICT) begin
            pol_if.row_conflict <= row_q[idx];
        end
    end

endmodule

//--- logic/wb_port_arbiter.sv
// Two Wishbone classic slave ports sharing the scheduler; round-robin grant, ack back to the winner
`timescale 1ns/1ps

module wb_port_arbiter (
    input  logic                           CLK,
    input  logic                           nRST,

    input  logic                           cyc0,
    input  logic                           stb0,
    input  logic                           we0,
    input  logic [dram_pkg::ADDR_BITS-1:0] adr0,
    input  logic [dram_pkg::DATA_BITS-1:0] dat_w0,
    output logic [dram_pkg::DATA_BITS-1:0] dat_r0,
    output logic                           ack0,

    input  logic                           cyc1,
    input  logic                           stb1,
    input  logic                           we1,
    input  logic [dram_pkg::ADDR_BITS-1:0] adr1,
    input  logic [dram_pkg::DATA_BITS-1:0] dat_w1,
    output logic [dram_pkg::DATA_BITS-1:0] dat_r1,
    output logic                           ack1,

    bus_req_if.master                      req
);

    logic pend0;
    logic pend1;
    logic idle;
    logic grant;
    logic pick1;
    logic last_port;

    assign pend0 = cyc0 && stb0;
    assign pend1 = cyc1 && stb1;

    // Wait out the ack cycle so a host still holding stb is not granted twice
    assign idle  = !req.valid && !ack0 && !ack1;
    assign grant = idle && (pend0 || pend1);

    // Port 1 wins alone, or when both ask and port 0 was served last
    assign pick1 = pend1 && (!pend0 || !last_port);

    assign req.port = last_port;

    // Completion goes back to the port of the granted request
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req.valid <= 1'b0;
            last_port <= 1'b0;
            ack0      <= 1'b0;
            ack1      <= 1'b0;
        end else begin
            ack0 <= req.done && !req.port;
            ack1 <= req.done && req.port;
            if (req.done) begin
                req.valid <= 1'b0;
            end else if (grant) begin
                req.valid <= 1'b1;
                last_port <= pick1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (grant) begin
            req.we    <= pick1 ? we1 : we0;
            req.addr  <= pick1 ? adr1 : adr0;
            req.wdata <= pick1 ? dat_w1 : dat_w0;
        end
        if (req.done && !req.port) begin
            dat_r0 <= req.rdata;
        end
        if (req.done && req.port) begin
            dat_r1 <= req.rdata;
        end
    end

endmodule

//--- logic/cmd_scheduler.sv
// Turns one granted request into a PRE/ACT/RD/WR sequence from the row table answer; also runs refresh
`timescale 1ns/1ps

module cmd_scheduler (
    input  logic                           CLK,
    input  logic                           nRST,
    bus_req_if.slave                       req,
    row_open_if.ctrl                       pol,
    output dram_pkg::dram_cmd_t            cmd,
    output logic [dram_pkg::BG_BITS-1:0]   cmd_bg,
    output logic [dram_pkg::BANK_BITS-1:0] cmd_bank,
    output logic [dram_pkg::ROW_BITS-1:0]  cmd_row,
    output logic [dram_pkg::COL_BITS-1:0]  cmd_col,
    output logic [dram_pkg::DATA_BITS-1:0] dq_out,
    input  logic [dram_pkg::DATA_BITS-1:0] dq_in
);
    import dram_pkg::*;

    sched_state_t            state;
    sched_state_t            state_n;
    logic [REF_CNT_BITS-1:0] ref_cnt;
    logic                    ref_due;

    logic [ROW_BITS-1:0]     addr_row;
    logic [BG_BITS-1:0]      addr_bg;
    logic [BANK_BITS-1:0]    addr_bank;
    logic [COL_BITS-1:0]     addr_col;

    // Address split, row on top
    assign addr_col  = req.addr[COL_BITS-1:0];
    assign addr_bank = req.addr[COL_BITS +: BANK_BITS];
    assign addr_bg   = req.addr[COL_BITS+BANK_BITS +: BG_BITS];
    assign addr_row  = req.addr[ADDR_BITS-1 -: ROW_BITS];

    // Refresh timer
    assign ref_due = ref_cnt == '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ref_cnt <= REF_CNT_BITS'(REFRESH_INTERVAL - 1);
        end else if (state == S_REF) begin
            ref_cnt <= REF_CNT_BITS'(REFRESH_INTERVAL - 1);
        end else if (!ref_due) begin
            ref_cnt <= ref_cnt - 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= S_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            // Refresh only between requests
            S_IDLE: begin
                if (ref_due) begin
                    state_n = S_PREA;
                end else if (req.valid) begin
                    state_n = S_LOOKUP;
                end
            end
            S_LOOKUP: state_n = S_DECIDE;
            S_DECIDE: begin
                case (pol.row_stat)
                    HIT:      state_n = S_ACCESS;
                    MISS:     state_n = S_ACT;
                    CONFLICT: state_n = S_PRE;
                    default:  state_n = S_LOOKUP;
                endcase
            end
            // Re-lookup after the precharge, which then misses
            S_PRE:    state_n = S_LOOKUP;
            S_ACT:    state_n = S_ACCESS;
            S_ACCESS: state_n = S_DONE;
            S_DONE:   state_n = S_IDLE;
            S_PREA:   state_n = S_REF;
            S_REF:    state_n = S_IDLE;
            default:  state_n = S_IDLE;
        endcase
    end

    // Table lookups; PRE carries the resolve
    assign pol.req_en      = (state == S_LOOKUP) || (state == S_PRE);
    assign pol.row_resolve = state == S_PRE;
    assign pol.refresh     = state == S_REF;
    assign pol.bank_group  = addr_bg;
    assign pol.bank        = addr_bank;
    assign pol.row         = addr_row;

    always_comb begin
        case (state)
            S_PRE:    cmd = PRE;
            S_ACT:    cmd = ACT;
            S_ACCESS: cmd = req.we ? WR : RD;
            S_PREA:   cmd = PREA;
            S_REF:    cmd = REF;
            default:  cmd = NOP;
        endcase
    end

    assign cmd_bg   = addr_bg;
    assign cmd_bank = addr_bank;
    assign cmd_col  = addr_col;
    // PRE names the row being closed
    assign cmd_row  = (state == S_PRE) ? pol.row_conflict : addr_row;
    assign dq_out   = (cmd == WR) ? req.wdata : '0;

    // Read data arrives on dq_in the cycle after RD, same cycle as done
    assign req.done  = state == S_DONE;
    assign req.rdata = dq_in;

endmodule

//--- logic/dram_ctrl_top.sv
// DRAM command controller top; two Wishbone host ports in, DRAM command bus and data out
`timescale 1ns/1ps

module dram_ctrl_top (
    input  logic                           CLK,
    input  logic                           nRST,

    input  logic                           cyc0,
    input  logic                           stb0,
    input  logic                           we0,
    input  logic [dram_pkg::ADDR_BITS-1:0] adr0,
    input  logic [dram_pkg::DATA_BITS-1:0] dat_w0,
    output logic [dram_pkg::DATA_BITS-1:0] dat_r0,
    output logic                           ack0,

    input  logic                           cyc1,
    input  logic                           stb1,
    input  logic                           we1,
    input  logic [dram_pkg::ADDR_BITS-1:0] adr1,
    input  logic [dram_pkg::DATA_BITS-1:0] dat_w1,
    output logic [dram_pkg::DATA_BITS-1:0] dat_r1,
    output logic                           ack1,

    output dram_pkg::dram_cmd_t            cmd,
    output logic [dram_pkg::BG_BITS-1:0]   cmd_bg,
    output logic [dram_pkg::BANK_BITS-1:0] cmd_bank,
    output logic [dram_pkg::ROW_BITS-1:0]  cmd_row,
    output logic [dram_pkg::COL_BITS-1:0]  cmd_col,
    output logic [dram_pkg::DATA_BITS-1:0] dq_out,
    input  logic [dram_pkg::DATA_BITS-1:0] dq_in
);

    row_open_if pol_if ();
    bus_req_if  req_if ();

    wb_port_arbiter i_arb (
        .CLK(CLK), .nRST(nRST),
        .cyc0(cyc0), .stb0(stb0), .we0(we0), .adr0(adr0),
        .dat_w0(dat_w0), .dat_r0(dat_r0), .ack0(ack0),
        .cyc1(cyc1), .stb1(stb1), .we1(we1), .adr1(adr1),
        .dat_w1(dat_w1), .dat_r1(dat_r1), .ack1(ack1),
        .req(req_if.master)
    );

    cmd_scheduler i_sched (
        .CLK(CLK), .nRST(nRST),
        .req(req_if.slave), .pol(pol_if.ctrl),
        .cmd(cmd), .cmd_bg(cmd_bg), .cmd_bank(cmd_bank),
        .cmd_row(cmd_row), .cmd_col(cmd_col),
        .dq_out(dq_out), .dq_in(dq_in)
    );

    row_open i_rows (
        .CLK(CLK), .nRST(nRST),
        .pol_if(pol_if.dut)
    );

endmodule

//--- dv/dram_ctrl_properties.sv
// Concurrent checks on the DRAM command bus and Wishbone ack, bound into scheduler and arbiter
`timescale 1ns/1ps

module dram_ctrl_properties (
    input logic                           CLK,
    input logic                           nRST,
    input dram_pkg::dram_cmd_t            cmd,
    input logic [dram_pkg::BG_BITS-1:0]   cmd_bg,
    input logic [dram_pkg::BANK_BITS-1:0] cmd_bank,
    input logic                           ack0,
    input logic                           ack1
);
    import dram_pkg::*;

    logic [NUM_BANKS-1:0] bank_open;

    // Banks activated since their last precharge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            bank_open <= '0;
        end else if (cmd == PREA) begin
            bank_open <= '0;
        end else if (cmd == PRE) begin
            bank_open[{cmd_bg, cmd_bank}] <= 1'b0;
        end else if (cmd == ACT) begin
            bank_open[{cmd_bg, cmd_bank}] <= 1'b1;
        end
    end

    ack0_single: assert property (@(posedge CLK) disable iff (!nRST) ack0 |=> !ack0)
        else $error("ack0 stayed high for more than one cycle");
    ack1_single: assert property (@(posedge CLK) disable iff (!nRST) ack1 |=> !ack1)
        else $error("ack1 stayed high for more than one cycle");
    ref_after_prea: assert property (@(posedge CLK) disable iff (!nRST)
        cmd == REF |-> $past(cmd) == PREA)
        else $error("REF issued without PREA in the cycle before");
    access_open_bank: assert property (@(posedge CLK) disable iff (!nRST)
        (cmd == RD || cmd == WR) |-> bank_open[{cmd_bg, cmd_bank}])
        else $error("RD or WR issued to a bank with no open row");

endmodule

bind cmd_scheduler dram_ctrl_properties i_sched_props (
    .CLK(CLK), .nRST(nRST), .cmd(cmd), .cmd_bg(cmd_bg), .cmd_bank(cmd_bank),
    .ack0(1'b0), .ack1(1'b0)
);

bind wb_port_arbiter dram_ctrl_properties i_arb_props (
    .CLK(CLK), .nRST(nRST), .cmd(dram_pkg::NOP), .cmd_bg('0), .cmd_bank('0),
    .ack0(ack0), .ack1(ack1)
);

//--- dv/tb_dram_ctrl.sv
// Testbench for the DRAM controller; two random Wishbone hosts, a DRAM model and a command checker
`timescale 1ns/1ps

module tb_dram_ctrl;
    import dram_pkg::*;

    localparam logic [31:0] SEED        = 32'he1d3;
    localparam int          N_ACCESS    = 40;
    localparam int          ACK_TIMEOUT = 100;

    typedef struct packed {
        dram_cmd_t             cmd;
        logic [BG_BITS-1:0]    bg;
        logic [BANK_BITS-1:0]  bank;
        logic [ROW_BITS-1:0]   row;
        logic [COL_BITS-1:0]   col;
        logic [DATA_BITS-1:0]  data;
    } cmd_rec_t;

    typedef struct packed {
        logic [1:0]            n;
        dram_cmd_t [2:0]       cmds;
        logic [ROW_BITS-1:0]   pre_row;
        logic [DATA_BITS-1:0]  rdata;
    } expect_t;

    logic                 CLK;
    logic                 nRST;
    logic [1:0]           cyc;
    logic [1:0]           stb;
    logic [1:0]           we;
    logic [ADDR_BITS-1:0] adr [2];
    logic [DATA_BITS-1:0] dat_w [2];
    wire  [DATA_BITS-1:0] dat_r [2];
    wire  [1:0]           ack;
    dram_cmd_t            cmd;
    logic [BG_BITS-1:0]   cmd_bg;
    logic [BANK_BITS-1:0] cmd_bank;
    logic [ROW_BITS-1:0]  cmd_row;
    logic [COL_BITS-1:0]  cmd_col;
    logic [DATA_BITS-1:0] dq_out;
    logic [DATA_BITS-1:0] dq_in;

    logic [DATA_BITS-1:0] mem [bit [ADDR_BITS-1:0]];
    logic [DATA_BITS-1:0] ref_mem [bit [ADDR_BITS-1:0]];
    logic                 open_v [NUM_BANKS];
    logic [ROW_BITS-1:0]  open_row [NUM_BANKS];
    cmd_rec_t             rec_q [$];
    logic [ADDR_BITS-1:0] cmd_addr;
    logic                 rd_seen;
    logic [DATA_BITS-1:0] rd_word;
    logic [1:0]           host_done;
    logic                 alt_due;
    int                   alt_port;
    int                   err_cnt;
    int                   refreshes;
    int                   acc_cnt;
    int                   kind_cnt [3];

    dram_ctrl_top i_dut (
        .CLK(CLK), .nRST(nRST),
        .cyc0(cyc[0]), .stb0(stb[0]), .we0(we[0]), .adr0(adr[0]),
        .dat_w0(dat_w[0]), .dat_r0(dat_r[0]), .ack0(ack[0]),
        .cyc1(cyc[1]), .stb1(stb[1]), .we1(we[1]), .adr1(adr[1]),
        .dat_w1(dat_w[1]), .dat_r1(dat_r[1]), .ack1(ack[1]),
        .cmd(cmd), .cmd_bg(cmd_bg), .cmd_bank(cmd_bank), .cmd_row(cmd_row),
        .cmd_col(cmd_col), .dq_out(dq_out), .dq_in(dq_in)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Contents of a location never written
    function automatic logic [DATA_BITS-1:0] init_word(input logic [ADDR_BITS-1:0] a);
        return xorshift(SEED ^ {a, ~a});
    endfunction

    // Expected command list and read data for one access
    function automatic expect_t ref_access(input logic valid [NUM_BANKS],
                                           input logic [ROW_BITS-1:0] rows [NUM_BANKS],
                                           input logic [ADDR_BITS-1:0] a,
                                           input logic wr);
        expect_t             e;
        int                  idx;
        logic [ROW_BITS-1:0] row;
        idx = a[COL_BITS +: BG_BITS + BANK_BITS];
        row = a[ADDR_BITS-1 -: ROW_BITS];
        e = '0;
        if (valid[idx] && rows[idx] != row) begin
            e.cmds[e.n] = PRE;
            e.pre_row   = rows[idx];
            e.n         = e.n + 1'b1;
        end
        if (!valid[idx] || rows[idx] != row) begin
            e.cmds[e.n] = ACT;
            e.n         = e.n + 1'b1;
        end
        e.cmds[e.n] = wr ? WR : RD;
        e.n         = e.n + 1'b1;
        e.rdata     = ref_mem.exists(a) ? ref_mem[a] : init_word(a);
        return e;
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        report_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_ack(input int p);
        expect_t              e;
        cmd_rec_t             r;
        logic [ADDR_BITS-1:0] a;
        logic [ROW_BITS-1:0]  exp_row;
        string                name;
        a = adr[p];
        // Refresh between requests closes every row
        while (rec_q.size() > 0 && rec_q[0].cmd == PREA) begin
            void'(rec_q.pop_front());
            assert (rec_q.size() > 0 && rec_q[0].cmd == REF)
                else report_error("PREA was not followed by REF");
            void'(rec_q.pop_front());
            open_v = '{default: 1'b0};
            refreshes++;
        end
        e = ref_access(open_v, open_row, a, we[p]);
        name = $sformatf("port%0d access %0d", p, acc_cnt);
        acc_cnt++;
        kind_cnt[e.n - 1]++;
        assert (rec_q.size() == e.n)
            else report_value({name, " command count"}, e.n, rec_q.size());
        for (int i = 0; i < e.n; i++) begin
            r = rec_q[i];
            exp_row = (r.cmd == PRE) ? e.pre_row : a[ADDR_BITS-1 -: ROW_BITS];
            assert (r.cmd == e.cmds[i]) else report_value({name, " command"}, e.cmds[i], r.cmd);
            assert ({r.bg, r.bank} == a[COL_BITS +: BG_BITS + BANK_BITS])
                else report_value({name, " bank"}, a[COL_BITS +: 4], {r.bg, r.bank});
            assert (r.row == exp_row) else report_value({name, " row"}, exp_row, r.row);
            if (r.cmd == RD || r.cmd == WR) begin
                assert (r.col == a[COL_BITS-1:0])
                    else report_value({name, " column"}, a[COL_BITS-1:0], r.col);
            end
            if (r.cmd == WR) begin
                assert (r.data == dat_w[p]) else report_value({name, " dq_out"}, dat_w[p], r.data);
            end
        end
        rec_q.delete();
        open_v[a[COL_BITS +: 4]]   = 1'b1;
        open_row[a[COL_BITS +: 4]] = a[ADDR_BITS-1 -: ROW_BITS];
        if (we[p]) begin
            ref_mem[a] = dat_w[p];
        end else begin
            assert (dat_r[p] == e.rdata)
                else report_value({name, " read data"}, e.rdata, dat_r[p]);
        end
        // A port left waiting must be served next
        if (alt_due) begin
            assert (p == alt_port) else report_value({name, " port order"}, alt_port, p);
        end
        alt_due  = cyc[1 - p] && stb[1 - p];
        alt_port = 1 - p;
    endtask

    // DRAM model returns the word on dq_in the cycle after RD
    assign cmd_addr = {cmd_row, cmd_bg, cmd_bank, cmd_col};

    always @(negedge CLK) begin
        rd_seen = cmd == RD;
        if (cmd == WR) begin
            mem[cmd_addr] = dq_out;
        end
        if (rd_seen) begin
            rd_word = mem.exists(cmd_addr) ? mem[cmd_addr] : init_word(cmd_addr);
        end
    end

    always @(posedge CLK) begin
        dq_in <= rd_seen ? rd_word : '0;
    end

    // Command monitor and checker sample mid-cycle
    always @(negedge CLK) begin
        if (nRST && cmd != NOP) begin
            rec_q.push_back('{cmd, cmd_bg, cmd_bank, cmd_row, cmd_col, dq_out});
        end
        for (int p = 0; p < 2; p++) begin
            if (nRST && ack[p]) begin
                check_ack(p);
            end
        end
    end

    for (genvar g = 0; g < 2; g++) begin : host
        initial begin
            logic [31:0] rng;
            int          wait_cnt;
            logic        hold;
            rng  = SEED ^ g;
            hold = 1'b0;
            repeat (4) @(posedge CLK);
            for (int n = 0; n < N_ACCESS; n++) begin
                rng = xorshift(rng);
                // A held cycle takes its next request at the edge after ack
                if (!hold) begin
                    @(posedge CLK);
                end
                cyc[g]   <= 1'b1;
                stb[g]   <= 1'b1;
                we[g]    <= rng[0];
                // Four banks, four rows and four columns so that rows are reused often
                adr[g]   <= {6'h21, rng[9:8], 1'b0, rng[2], 1'b0, rng[3], 2'b00, rng[5:4]};
                dat_w[g] <= xorshift(rng ^ 32'h5a5a_0f0f);
                wait_cnt = 0;
                @(negedge CLK);
                while (!ack[g]) begin
                    wait_cnt++;
                    if (wait_cnt > ACK_TIMEOUT) begin
                        report_error($sformatf("no ack on port %0d within %0d cycles",
                                               g, ACK_TIMEOUT));
                    end
                    @(negedge CLK);
                end
                @(posedge CLK);
                hold = rng[12:11] == 2'd0 && n < N_ACCESS - 1;
                if (!hold) begin
                    cyc[g] <= 1'b0;
                    stb[g] <= 1'b0;
                    repeat (rng[12:11]) @(posedge CLK);
                end
            end
            host_done[g] <= 1'b1;
        end
    end

    initial begin
        int wait_cnt;
        nRST      = 1'b0;
        cyc       = '0;
        stb       = '0;
        we        = '0;
        adr       = '{default: '0};
        dat_w     = '{default: '0};
        dq_in     = '0;
        rd_seen   = 1'b0;
        open_v    = '{default: 1'b0};
        host_done = '0;
        alt_due   = 1'b0;
        alt_port  = 0;
        err_cnt   = 0;
        refreshes = 0;
        acc_cnt   = 0;
        kind_cnt  = '{default: 0};
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        wait_cnt = 0;
        while (host_done != 2'b11) begin
            wait_cnt++;
            if (wait_cnt > 20000) begin
                report_error("hosts did not finish their accesses in time");
            end
            @(posedge CLK);
        end
        assert (refreshes > 0) else report_error("no refresh was seen during the run");
        assert (kind_cnt[0] > 0) else report_error("no row hit was seen during the run");
        assert (kind_cnt[2] > 0) else report_error("no row conflict was seen during the run");
        if (err_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- sources.f
logic/dram_pkg.sv
logic/row_open_if.sv
logic/bus_req_if.sv
logic/row_open.sv
logic/wb_port_arbiter.sv
logic/cmd_scheduler.sv
logic/dram_ctrl_top.sv
dv/dram_ctrl_properties.sv
dv/tb_dram_ctrl.sv

//--- Bender.yml
package:
  name: dram_ctrl

sources:
  - logic/dram_pkg.sv
  - logic/row_open_if.sv
  - logic/bus_req_if.sv
  - logic/row_open.sv
  - logic/wb_port_arbiter.sv
  - logic/cmd_scheduler.sv
  - logic/dram_ctrl_top.sv
  - target: test
    files:
      - dv/dram_ctrl_properties.sv
      - dv/tb_dram_ctrl.sv
